//--- src/pe_package.sv
// Pixel engine package with shared widths, register map, mode fields and sizes
package pe_package;

  // Basic widths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 16;
  localparam int PEL_W  = 16;
  localparam int PROD_W = 24;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PEL_W-1:0]  pel_t;
  typedef logic [15:0]       len_t;
  typedef logic [2:0]        reg_idx_t;
  // Pixel times 8-bit gain
  typedef logic [PROD_W-1:0] prod_t;

  // FSM states
  typedef enum logic {CTRL_IDLE, CTRL_RUN}   ctrl_state_e;
  typedef enum logic {LOAD_IDLE, LOAD_FETCH} load_state_e;

  // Register map
  localparam reg_idx_t REG_SRC    = 3'd0;
  localparam reg_idx_t REG_DST    = 3'd1;
  localparam reg_idx_t REG_LEN    = 3'd2;
  localparam reg_idx_t REG_MODE   = 3'd3;
  localparam reg_idx_t REG_START  = 3'd4;
  localparam reg_idx_t REG_STATUS = 3'd5;

  // Mode register fields
  localparam int GAIN_LSB   = 0;
  localparam int GAIN_MSB   = 7;
  localparam int SHIFT_LSB  = 8;
  localparam int SHIFT_MSB  = 11;
  localparam int OP_BIT     = 12;
  localparam int THRESH_LSB = 16;
  localparam int THRESH_MSB = 31;

  // Result FIFO and credit sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [CNT_W-1:0]      cnt_t;

  // Saturation limit
  localparam pel_t PEL_MAX = 16'hFFFF;

endpackage

//--- src/pe_ctrl.sv
// Pixel engine control unit with register file, job sequencing and done event
`timescale 1ns/1ps

module pe_ctrl import pe_package::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Peripheral bus
  input  logic     cfg_we_i,
  input  logic     cfg_re_i,
  input  reg_idx_t cfg_addr_i,
  input  word_t    cfg_wdata_i,
  output word_t    cfg_rdata_o,
  // Job done event
  output logic     evt_o,
  // Datapath control
  output logic     start_o,
  output addr_t    src_base_o,
  output addr_t    dst_base_o,
  output len_t     len_o,
  output word_t    mode_o,
  input  logic     done_i
);

  ctrl_state_e state_q;
  addr_t       src_q;
  addr_t       dst_q;
  len_t        len_q;
  word_t       mode_q;
  logic        busy;
  logic        start_hit;

  assign busy = (state_q == CTRL_RUN);

  // Start command seen while idle
  assign start_hit = cfg_we_i && (cfg_addr_i == REG_START) && !busy;
  // Zero length never reaches the datapath
  assign start_o   = start_hit && (len_q != '0);

  // Job settings held stable for the whole job
  assign src_base_o = src_q;
  assign dst_base_o = dst_q;
  assign len_o      = len_q;
  assign mode_o     = mode_q;

  // Config registers, writable only while idle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      len_q  <= '0;
      mode_q <= '0;
    end else if (cfg_we_i && !busy) begin
      case (cfg_addr_i)
        REG_SRC:  src_q  <= cfg_wdata_i[ADDR_W-1:0];
        REG_DST:  dst_q  <= cfg_wdata_i[ADDR_W-1:0];
        REG_LEN:  len_q  <= cfg_wdata_i[15:0];
        REG_MODE: mode_q <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // Job FSM and event pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= CTRL_IDLE;
      evt_o   <= 1'b0;
    end else begin
      // Event for storer done or empty job
      evt_o <= (busy && done_i) || (start_hit && (len_q == '0));
      case (state_q)
        CTRL_IDLE: if (start_o) state_q <= CTRL_RUN;
        CTRL_RUN:  if (done_i) state_q <= CTRL_IDLE;
        default:   state_q <= CTRL_IDLE;
      endcase
    end
  end

  // Read data one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (cfg_re_i) begin
      case (cfg_addr_i)
        REG_SRC:    cfg_rdata_o <= word_t'(src_q);
        REG_DST:    cfg_rdata_o <= word_t'(dst_q);
        REG_LEN:    cfg_rdata_o <= word_t'(len_q);
        REG_MODE:   cfg_rdata_o <= mode_q;
        REG_STATUS: cfg_rdata_o <= word_t'(busy);
        default:    cfg_rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- src/pe_loader.sv
// Pixel loader issuing credit-limited source reads and emitting pixel strobes
`timescale 1ns/1ps

module pe_loader import pe_package::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  start_i,
  input  addr_t src_base_i,
  input  len_t  len_i,
  input  logic  credit_i,
  // Memory read request
  output logic  req_o,
  output addr_t addr_o,
  input  logic  gnt_i,
  input  word_t rdata_i,
  // Pixel stream to engine
  output logic  pel_valid_o,
  output pel_t  pel_data_o
);

  load_state_e state_q;
  addr_t       addr_q;
  len_t        remain_q;
  cnt_t        credit_q;
  logic        issue;

  // Read only with a free slot in the storer FIFO
  assign req_o  = (state_q == LOAD_FETCH) && (credit_q != '0);
  assign issue  = req_o && gnt_i;
  assign addr_o = addr_q;

  // FSM, remaining count and credits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= LOAD_IDLE;
      remain_q <= '0;
      credit_q <= '0;
    end else if (start_i) begin
      state_q  <= LOAD_FETCH;
      remain_q <= len_i;
      credit_q <= cnt_t'(FIFO_DEPTH);
    end else begin
      // Spend on issue, refill on storer write
      credit_q <= credit_q - cnt_t'(issue) + cnt_t'(credit_i);
      if (issue) begin
        remain_q <= remain_q - len_t'(1);
        // Last read issued
        if (remain_q == len_t'(1)) state_q <= LOAD_IDLE;
      end
    end
  end

  // Source address walk
  always_ff @(posedge clk_i) begin
    if (start_i) addr_q <= src_base_i;
    else if (issue) addr_q <= addr_q + addr_t'(1);
  end

  // Read data lands one cycle after grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) pel_valid_o <= 1'b0;
    else pel_valid_o <= issue;
  end

  // High half of the word is ignored
  assign pel_data_o = rdata_i[PEL_W-1:0];

endmodule

//--- src/pe_engine.sv
// Pixel engine with two-stage scale-and-saturate or threshold pipeline
`timescale 1ns/1ps

module pe_engine import pe_package::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  word_t mode_i,
  input  logic  pel_valid_i,
  input  pel_t  pel_data_i,
  output logic  res_valid_o,
  output pel_t  res_data_o
);

  logic  v1_q;
  logic  op1_q;
  prod_t prod_q;
  logic  ge_q;
  prod_t shifted;
  pel_t  sat;

  // Valid bits follow the data through both stages
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v1_q        <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      v1_q        <= pel_valid_i;
      res_valid_o <= v1_q;
    end
  end

  // Stage one
  always_ff @(posedge clk_i) begin
    op1_q  <= mode_i[OP_BIT];
    // Gain product, 16 x 8 bits
    prod_q <= prod_t'(pel_data_i) * prod_t'(mode_i[GAIN_MSB:GAIN_LSB]);
    // Threshold compare
    ge_q   <= (pel_data_i >= mode_i[THRESH_MSB:THRESH_LSB]);
  end

  // Shift then clamp to the pixel range
  assign shifted = prod_q >> mode_i[SHIFT_MSB:SHIFT_LSB];
  assign sat     = (shifted > prod_t'(PEL_MAX)) ? PEL_MAX : shifted[PEL_W-1:0];

  // Stage two
  always_ff @(posedge clk_i) begin
    if (op1_q) begin
      // Threshold gives all ones or zero
      res_data_o <= ge_q ? PEL_MAX : '0;
    end else begin
      res_data_o <= sat;
    end
  end

endmodule

//--- src/pe_storer.sv
// Result storer with FIFO buffering, destination writes, credit return and done
`timescale 1ns/1ps

module pe_storer import pe_package::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  start_i,
  input  addr_t dst_base_i,
  input  len_t  len_i,
  // Results from engine, never stalled
  input  logic  res_valid_i,
  input  pel_t  res_data_i,
  // Memory write request
  output logic  req_o,
  output addr_t addr_o,
  output word_t wdata_o,
  input  logic  gnt_i,
  // Back to loader and control
  output logic  credit_o,
  output logic  done_o
);

  pel_t      fifo_q [FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  cnt_t      count_q;
  addr_t     addr_q;
  len_t      remain_q;
  logic      pop;

  // Write whenever something is buffered
  assign req_o   = (count_q != '0);
  assign pop     = req_o && gnt_i;
  assign addr_o  = addr_q;
  // Upper half written as zero
  assign wdata_o = {{(WORD_W-PEL_W){1'b0}}, fifo_q[rd_ptr_q]};

  // FIFO storage
  always_ff @(posedge clk_i) begin
    if (res_valid_i) fifo_q[wr_ptr_q] <= res_data_i;
  end

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (res_valid_i) wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
      if (pop) rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
      // Credits keep this within depth
      count_q <= count_q + cnt_t'(res_valid_i) - cnt_t'(pop);
    end
  end

  // Remaining writes, credit and done strobes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      remain_q <= '0;
      credit_o <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      // One credit per entry written out
      credit_o <= pop;
      // Last write granted
      done_o   <= pop && (remain_q == len_t'(1));
      if (start_i) remain_q <= len_i;
      else if (pop) remain_q <= remain_q - len_t'(1);
    end
  end

  // Destination address walk
  always_ff @(posedge clk_i) begin
    if (start_i) addr_q <= dst_base_i;
    else if (pop) addr_q <= addr_q + addr_t'(1);
  end

endmodule

//--- src/pe_mem_arbiter.sv
// Round-robin arbiter sharing the memory port between loader and storer
`timescale 1ns/1ps

module pe_mem_arbiter import pe_package::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Loader, read only
  input  logic  ld_req_i,
  input  addr_t ld_addr_i,
  output logic  ld_gnt_o,
  // Storer, write only
  input  logic  st_req_i,
  input  addr_t st_addr_i,
  input  word_t st_wdata_i,
  output logic  st_gnt_o,
  // Shared memory port
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output word_t mem_wdata_o,
  input  logic  mem_gnt_i
);

  logic prio_st_q;
  logic lock_q;
  logic lock_st_q;
  logic rr_st;
  logic sel_st;

  // Storer wins if alone or when it holds priority
  assign rr_st  = st_req_i && (!ld_req_i || prio_st_q);
  // A stalled request keeps its master until granted
  assign sel_st = lock_q ? lock_st_q : rr_st;

  assign mem_req_o   = ld_req_i || st_req_i;
  assign mem_we_o    = sel_st;
  assign mem_addr_o  = sel_st ? st_addr_i : ld_addr_i;
  assign mem_wdata_o = sel_st ? st_wdata_i : '0;

  // Grant goes back to the chosen master
  assign ld_gnt_o = mem_gnt_i && ld_req_i && !sel_st;
  assign st_gnt_o = mem_gnt_i && sel_st;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_st_q <= 1'b0;
      lock_q    <= 1'b0;
      lock_st_q <= 1'b0;
    end else if (mem_req_o) begin
      if (mem_gnt_i) begin
        // Served master goes second next time
        prio_st_q <= !sel_st;
        lock_q    <= 1'b0;
      end else begin
        lock_q    <= 1'b1;
        lock_st_q <= sel_st;
      end
    end
  end

endmodule

//--- src/pe_top.sv
// Pixel engine top connecting control, loader, engine, storer and arbiter
`timescale 1ns/1ps

module pe_top import pe_package::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Peripheral bus
  input  logic     cfg_we_i,
  input  logic     cfg_re_i,
  input  reg_idx_t cfg_addr_i,
  input  word_t    cfg_wdata_i,
  output word_t    cfg_rdata_o,
  output logic     evt_o,
  // Shared memory port
  output logic     mem_req_o,
  output logic     mem_we_o,
  output addr_t    mem_addr_o,
  output word_t    mem_wdata_o,
  input  logic     mem_gnt_i,
  input  word_t    mem_rdata_i
);

  // Job control
  logic  start;
  addr_t src_base;
  addr_t dst_base;
  len_t  len;
  word_t mode;
  logic  done;
  logic  credit;
  // Master requests
  logic  ld_req;
  addr_t ld_addr;
  logic  ld_gnt;
  logic  st_req;
  addr_t st_addr;
  word_t st_wdata;
  logic  st_gnt;
  // Pixel path
  logic  pel_valid;
  pel_t  pel_data;
  logic  res_valid;
  pel_t  res_data;

  pe_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_re_i    (cfg_re_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .evt_o       (evt_o),
    .start_o     (start),
    .src_base_o  (src_base),
    .dst_base_o  (dst_base),
    .len_o       (len),
    .mode_o      (mode),
    .done_i      (done)
  );

  pe_loader u_loader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .src_base_i  (src_base),
    .len_i       (len),
    .credit_i    (credit),
    .req_o       (ld_req),
    .addr_o      (ld_addr),
    .gnt_i       (ld_gnt),
    .rdata_i     (mem_rdata_i),
    .pel_valid_o (pel_valid),
    .pel_data_o  (pel_data)
  );

  pe_engine u_engine (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mode_i      (mode),
    .pel_valid_i (pel_valid),
    .pel_data_i  (pel_data),
    .res_valid_o (res_valid),
    .res_data_o  (res_data)
  );

  pe_storer u_storer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .dst_base_i  (dst_base),
    .len_i       (len),
    .res_valid_i (res_valid),
    .res_data_i  (res_data),
    .req_o       (st_req),
    .addr_o      (st_addr),
    .wdata_o     (st_wdata),
    .gnt_i       (st_gnt),
    .credit_o    (credit),
    .done_o      (done)
  );

  pe_mem_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ld_req_i    (ld_req),
    .ld_addr_i   (ld_addr),
    .ld_gnt_o    (ld_gnt),
    .st_req_i    (st_req),
    .st_addr_i   (st_addr),
    .st_wdata_i  (st_wdata),
    .st_gnt_o    (st_gnt),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_gnt_i   (mem_gnt_i)
  );

endmodule

//--- testbench/pe_assertions.sv
// Concurrent checks on the shared memory handshake and the job done event
`timescale 1ns/1ps

module pe_assertions import pe_package::*; (
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  req_i,
  input logic  we_i,
  input addr_t addr_i,
  input word_t wdata_i,
  input logic  gnt_i,
  input logic  ld_gnt_i,
  input logic  st_gnt_i,
  input logic  evt_i
);

  // Raised by any failing property, watched from the testbench
  logic violated = 1'b0;

  // Stalled request keeps direction, address and data
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !gnt_i |=> req_i && $stable(we_i) && $stable(addr_i) && $stable(wdata_i))
    else begin
      $error("memory request changed before grant");
      violated = 1'b1;
    end

  // Each granted request reaches exactly one master
  gnt_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && gnt_i |-> ld_gnt_i ^ st_gnt_i)
    else begin
      $error("memory grant not routed to exactly one master");
      violated = 1'b1;
    end

  // Done event is a single-cycle pulse
  evt_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_i |=> !evt_i)
    else begin
      $error("event held for more than one cycle");
      violated = 1'b1;
    end

endmodule

// Memory side checks on the arbiter
bind pe_mem_arbiter pe_assertions u_mem_sva (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (mem_req_o),
  .we_i     (mem_we_o),
  .addr_i   (mem_addr_o),
  .wdata_i  (mem_wdata_o),
  .gnt_i    (mem_gnt_i),
  .ld_gnt_i (ld_gnt_o),
  .st_gnt_i (st_gnt_o),
  .evt_i    (1'b0)
);

// Event check on the control unit, handshake inputs tied off
bind pe_ctrl pe_assertions u_evt_sva (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (1'b0),
  .we_i     (1'b0),
  .addr_i   ('0),
  .wdata_i  ('0),
  .gnt_i    (1'b0),
  .ld_gnt_i (1'b0),
  .st_gnt_i (1'b0),
  .evt_i    (evt_o)
);

//--- testbench/tb_pe_top.sv
// Testbench for the pixel engine with memory model, random jobs and reference model
`timescale 1ns/1ps

module tb_pe_top import pe_package::*; ();

  logic     clk_i;
  logic     rst_n_i;
  logic     cfg_we_i;
  logic     cfg_re_i;
  reg_idx_t cfg_addr_i;
  word_t    cfg_wdata_i;
  word_t    cfg_rdata_o;
  logic     evt_o;
  logic     mem_req_o;
  logic     mem_we_o;
  addr_t    mem_addr_o;
  word_t    mem_wdata_o;
  logic     mem_gnt_i;
  word_t    mem_rdata_i;

  // Shared memory image
  word_t       mem [65536];
  logic        rd_pend;
  addr_t       rd_addr;
  int unsigned write_count;
  int unsigned evt_count;
  int unsigned error_count;
  logic [31:0] stim_state;
  logic [31:0] gnt_state;

  pe_top u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_re_i    (cfg_re_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .evt_o       (evt_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_rdata_i (mem_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // LCG step
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Upper halves only, low LCG bits are weak
  function word_t rand_word();
    word_t a;
    word_t b;
    stim_state = lcg_step(stim_state);
    a = stim_state;
    stim_state = lcg_step(stim_state);
    b = stim_state;
    return {a[31:16], b[31:16]};
  endfunction

  function int unsigned rand_below(input int unsigned n);
    return rand_word() % n;
  endfunction

  // Expected pixel from the operation rules
  function automatic pel_t ref_pixel(input pel_t pel, input word_t mode);
    longint unsigned val;
    if (mode[12]) begin
      return (pel >= mode[31:16]) ? 16'hFFFF : 16'h0000;
    end
    val = longint'(pel) * longint'(mode[7:0]);
    val = val >> mode[11:8];
    if (val > 65535) return 16'hFFFF;
    return pel_t'(val);
  endfunction

  task report_failure(input string why);
    error_count++;
    $display("ERROR: %s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "simulation stopped on mismatch");
    end
  endtask

  // Handshake seen mid-cycle, completes at the next edge
  always @(negedge clk_i) begin
    rd_pend = 1'b0;
    if (rst_n_i && mem_req_o && mem_gnt_i) begin
      if (!mem_we_o) begin
        rd_pend = 1'b1;
        rd_addr = mem_addr_o;
      end else begin
        mem[mem_addr_o] = mem_wdata_o;
        write_count++;
      end
    end
  end

  // Read data one cycle after grant, grant about 70 percent of cycles
  always @(posedge clk_i) begin
    #1;
    mem_rdata_i = rd_pend ? mem[rd_addr] : '0;
    gnt_state = lcg_step(gnt_state);
    mem_gnt_i = rst_n_i && ((gnt_state[31:16] % 100) < 70);
  end

  always @(negedge clk_i) begin
    if (rst_n_i && evt_o) evt_count++;
    if (u_dut.u_arbiter.u_mem_sva.violated || u_dut.u_ctrl.u_evt_sva.violated) begin
      report_failure("a bound assertion on the DUT failed");
    end
  end

  // Bus tasks start and end 1 ns after an edge
  task cfg_write(input reg_idx_t a, input word_t d);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = a;
    cfg_wdata_i = d;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task cfg_read(input reg_idx_t a, output word_t d);
    cfg_re_i   = 1'b1;
    cfg_addr_i = a;
    @(posedge clk_i);
    #1;
    cfg_re_i = 1'b0;
    d = cfg_rdata_o;
  endtask

  task wait_event(input int unsigned target, input int unsigned limit);
    int unsigned n;
    n = 0;
    while (evt_count < target) begin
      if (n == limit) begin
        report_failure("timeout waiting for the job done event");
      end else begin
        @(posedge clk_i);
        #1;
        n++;
      end
    end
  endtask

  task automatic run_job(input string name, input logic op, input logic probe,
                         input int unsigned len);
    addr_t       src;
    addr_t       dst;
    word_t       mode;
    word_t       rd;
    word_t       guard;
    word_t       src_words [$];
    int unsigned wr_base;
    int unsigned evt_base;
    src  = addr_t'(rand_below(32'h7F00));
    dst  = addr_t'(32'h8000 + rand_below(32'h7F00));
    mode = rand_word();
    mode[15:13] = 3'b000;
    mode[12]    = op;
    // Random high halves must be ignored by the loader
    for (int i = 0; i < len; i++) begin
      src_words.push_back(rand_word());
      mem[addr_t'(src + i)] = src_words[i];
    end
    guard    = mem[addr_t'(dst + len)];
    wr_base  = write_count;
    evt_base = evt_count;
    cfg_write(REG_SRC, word_t'(src));
    cfg_write(REG_DST, word_t'(dst));
    cfg_write(REG_LEN, word_t'(len));
    cfg_write(REG_MODE, mode);
    cfg_write(REG_START, '0);
    if (probe) begin
      cfg_read(REG_STATUS, rd);
      check_value({name, " status busy"}, 32'h1, rd);
      // Second start and a length write while running
      cfg_write(REG_START, '0);
      cfg_write(REG_LEN, word_t'(len + 5));
      cfg_read(REG_LEN, rd);
      check_value({name, " length held"}, word_t'(len), rd);
    end
    wait_event(evt_base + 1, 400 + 40 * len);
    repeat (8) @(posedge clk_i);
    #1;
    check_value({name, " event count"}, evt_base + 1, evt_count);
    check_value({name, " write count"}, wr_base + len, write_count);
    cfg_read(REG_STATUS, rd);
    check_value({name, " status idle"}, 32'h0, rd);
    for (int i = 0; i < len; i++) begin
      check_value($sformatf("%s pixel %0d", name, i),
                  {16'h0000, ref_pixel(src_words[i][15:0], mode)}, mem[addr_t'(dst + i)]);
      check_value($sformatf("%s source %0d", name, i), src_words[i], mem[addr_t'(src + i)]);
    end
    check_value({name, " guard word"}, guard, mem[addr_t'(dst + len)]);
  endtask

  initial begin
    word_t       v;
    word_t       rd;
    int unsigned evt_base;
    int unsigned wr_base;
    cfg_we_i    = 1'b0;
    cfg_re_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    mem_gnt_i   = 1'b0;
    mem_rdata_i = '0;
    rst_n_i     = 1'b0;
    rd_pend     = 1'b0;
    rd_addr     = '0;
    write_count = 0;
    evt_count   = 0;
    error_count = 0;
    stim_state  = 32'd51;
    gnt_state   = 32'd51;
    // Background fill, every word tied to its address
    for (int a = 0; a < 65536; a++) begin
      mem[a] = {16'(a) ^ 16'h5A3C, ~16'(a)};
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_value("reset mem_req", 32'h0, word_t'(mem_req_o));
    check_value("reset evt", 32'h0, word_t'(evt_o));

    // Register file round trip
    v = rand_word();
    cfg_write(REG_SRC, v);
    cfg_read(REG_SRC, rd);
    check_value("regfile src", {16'h0000, v[15:0]}, rd);
    v = rand_word();
    cfg_write(REG_DST, v);
    cfg_read(REG_DST, rd);
    check_value("regfile dst", {16'h0000, v[15:0]}, rd);
    v = rand_word();
    cfg_write(REG_LEN, v);
    cfg_read(REG_LEN, rd);
    check_value("regfile len", {16'h0000, v[15:0]}, rd);
    v = rand_word();
    cfg_write(REG_MODE, v);
    cfg_read(REG_MODE, rd);
    check_value("regfile mode", v, rd);

    // Scale and threshold jobs under random grant stalls
    for (int j = 0; j < 6; j++) begin
      run_job($sformatf("scale job %0d", j), 1'b0, 1'b0, 1 + rand_below(40));
    end
    for (int j = 0; j < 6; j++) begin
      run_job($sformatf("threshold job %0d", j), 1'b1, 1'b0, 1 + rand_below(40));
    end
    run_job("busy job", 1'b0, 1'b1, 32);

    // Empty job gives the event and no writes
    evt_base = evt_count;
    wr_base  = write_count;
    cfg_write(REG_LEN, '0);
    cfg_write(REG_START, '0);
    wait_event(evt_base + 1, 50);
    repeat (8) @(posedge clk_i);
    #1;
    check_value("zero job event count", evt_base + 1, evt_count);
    check_value("zero job write count", wr_base, write_count);

    if (error_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "simulation ended with errors");
    end
  end

endmodule

//--- compile.f
src/pe_package.sv
src/pe_ctrl.sv
src/pe_loader.sv
src/pe_engine.sv
src/pe_storer.sv
src/pe_mem_arbiter.sv
src/pe_top.sv
testbench/pe_assertions.sv
testbench/tb_pe_top.sv

//--- Bender.yml
package:
  name: pe_accel

sources:
  - src/pe_package.sv
  - src/pe_ctrl.sv
  - src/pe_loader.sv
  - src/pe_engine.sv
  - src/pe_storer.sv
  - src/pe_mem_arbiter.sv
  - src/pe_top.sv
  - target: test
    files:
      - testbench/pe_assertions.sv
      - testbench/tb_pe_top.sv
